// ==== logic/rx_format_pkg.sv ====
// word width, byte and field layout, and word kinds of the receive packet stream

package rx_format_pkg;

    // one stream word
    localparam int word_w         = 64;
    localparam int bytes_per_word = word_w / 8;

    typedef logic [word_w-1:0] word_t;

    // same width as pkt_len from the receiver
    typedef logic [15:0] len_t;
    typedef logic [15:0] seq_t;

    // content selector of the packer output word
    typedef enum logic [1:0]
    {
        kind_header,
        kind_data,
        kind_status
    } word_kind_e;

    // header word: length, rate, reserved byte, low half of the TSF timer
    localparam int hdr_len_lsb  = 0;
    localparam int hdr_rate_lsb = 16;
    localparam int hdr_rate_w   = 8;
    localparam int hdr_tsf_lsb  = 32;
    localparam int hdr_tsf_w    = 32;

    // status word: FCS result in bit 0, sequence number above, rest zero
    localparam int sts_fcs_bit = 0;
    localparam int sts_seq_lsb = 16;

endpackage

// ==== logic/rx_fsm_pkg.sv ====
// state encodings of the packer and the stream master FSMs

package rx_fsm_pkg;

    // packer states, one packet from header strobe to status push
    typedef enum logic [2:0]
    {
        pk_idle,
        pk_header,
        pk_bytes,
        pk_flush,
        pk_status,
        pk_dropping
    } packer_state_e;

    // stream master, whether a packet is open on the stream port
    typedef enum logic
    {
        st_idle,
        st_streaming
    } streamer_state_e;

endpackage

// ==== logic/rx_word_if.sv ====
// credit-based word link between design blocks, with sender and receiver modports
`timescale 1ns/1ps

interface rx_word_if
    import rx_format_pkg::*;
#(
    parameter int slots = 32
)
();

    localparam int level_w = $clog2(slots + 1);

    // driven by the sender, one word per valid cycle
    logic               valid;
    word_t              data;
    // marks the status word that closes a packet
    logic               last;

    // one-cycle pulse per slot freed at the receiver
    logic               credit;
    // receiver occupancy, debug only
    logic [level_w-1:0] level;

    modport sender
    (
        output valid,
        output data,
        output last,
        input  credit,
        input  level
    );

    modport receiver
    (
        input  valid,
        input  data,
        input  last,
        output credit,
        output level
    );

endinterface

// ==== logic/rx_word_packer.sv ====
// packer from receiver bytes to header, data and status words, with credit admission
`timescale 1ns/1ps

module rx_word_packer
    import rx_format_pkg::*;
    import rx_fsm_pkg::*;
#(
    parameter int fifo_depth = 32
)
(
    input  logic        m00_axis_aclk,
    input  logic        arst_n,
    input  logic        pkt_header_valid,
    input  logic        pkt_header_valid_strobe,
    input  logic [7:0]  pkt_rate,
    input  len_t        pkt_len,
    input  logic [7:0]  byte_in,
    input  logic        byte_in_strobe,
    input  logic        fcs_in_strobe,
    input  logic        fcs_ok,
    input  logic [63:0] tsf_runtime_val,
    output logic [15:0] dropped_pkt_count,
    rx_word_if.sender   push
);

    localparam int cred_w = $clog2(fifo_depth + 1);
    localparam int need_w = $bits(len_t) + 1;
    localparam int idx_w  = $clog2(bytes_per_word);

    packer_state_e     state;
    word_kind_e        kind;
    logic              emit;
    logic [cred_w-1:0] credits;
    logic [cred_w-1:0] credits_next;
    logic [need_w-1:0] need;
    logic              fits;
    logic              hdr_acc;
    logic              take_byte;
    logic              last_byte;
    logic              word_done;
    logic [idx_w-1:0]  byte_idx;
    len_t              len_q;
    len_t              byte_cnt;
    seq_t              seq_q;
    word_t             gather_q;
    word_t             gather_word;
    word_t             next_word;

    assign credits_next = credits + cred_w'(push.credit) - cred_w'(push.valid);

    // header + data words + status
    assign need = need_w'(2) + ((need_w'(pkt_len) + need_w'(bytes_per_word - 1))
                                / need_w'(bytes_per_word));
    assign fits = need_w'(credits_next) >= need;

    // a new header is taken once the previous packet is closed
    assign hdr_acc   = pkt_header_valid_strobe && pkt_header_valid
                       && (state == pk_idle || state == pk_status);
    assign take_byte = byte_in_strobe && (state == pk_header || state == pk_bytes);
    assign byte_idx  = byte_cnt[idx_w-1:0];
    assign last_byte = (byte_cnt + len_t'(1)) == len_q;
    assign word_done = byte_idx == idx_w'(bytes_per_word - 1);

    always_comb
    begin
        gather_word = gather_q;
        gather_word[byte_idx*8 +: 8] = byte_in;
    end

    // at most one word kind can fire, the states keep them apart
    always_comb
    begin
        emit = 1'b0;
        kind = kind_data;
        if (hdr_acc && fits)
        begin
            emit = 1'b1;
            kind = kind_header;
        end
        else if (take_byte && (word_done || last_byte))
        begin
            emit = 1'b1;
            kind = kind_data;
        end
        else if (state == pk_flush && fcs_in_strobe)
        begin
            emit = 1'b1;
            kind = kind_status;
        end
    end

    always_comb
    begin
        next_word = '0;
        case (kind)
            kind_header:
            begin
                next_word[hdr_len_lsb +: $bits(len_t)] = pkt_len;
                next_word[hdr_rate_lsb +: hdr_rate_w]  = pkt_rate;
                next_word[hdr_tsf_lsb +: hdr_tsf_w]    = tsf_runtime_val[hdr_tsf_w-1:0];
            end
            kind_status:
            begin
                next_word[sts_fcs_bit]                 = fcs_ok;
                next_word[sts_seq_lsb +: $bits(seq_t)] = seq_q;
            end
            default:
                next_word = gather_word;
        endcase
    end

    always_ff @(posedge m00_axis_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state             <= pk_idle;
            credits           <= cred_w'(fifo_depth);
            byte_cnt          <= '0;
            seq_q             <= '0;
            dropped_pkt_count <= '0;
            push.valid        <= 1'b0;
            push.last         <= 1'b0;
        end
        else
        begin
            credits    <= credits_next;
            push.valid <= emit;
            push.last  <= emit && kind == kind_status;
            // sequence advances for admitted packets only
            if (emit && kind == kind_status)
                seq_q <= seq_q + seq_t'(1);
            if (hdr_acc && !fits)
                dropped_pkt_count <= dropped_pkt_count + 16'd1;
            if (hdr_acc)
                byte_cnt <= '0;
            else if (take_byte)
                byte_cnt <= byte_cnt + len_t'(1);

            case (state)
                pk_idle, pk_status:
                begin
                    if (hdr_acc)
                        state <= fits ? pk_header : pk_dropping;
                    else
                        state <= pk_idle;
                end
                pk_header, pk_bytes:
                begin
                    if (take_byte && last_byte)
                        state <= pk_flush;
                    else if (state == pk_header && len_q == '0)
                        state <= pk_flush;
                    else
                        state <= pk_bytes;
                end
                // last data word is out, wait for the FCS result
                pk_flush:
                    if (fcs_in_strobe)
                        state <= pk_status;
                pk_dropping:
                    if (fcs_in_strobe)
                        state <= pk_idle;
                default:
                    state <= pk_idle;
            endcase
        end
    end

    always_ff @(posedge m00_axis_aclk)
    begin
        if (emit)
            push.data <= next_word;
        if (hdr_acc)
        begin
            len_q    <= pkt_len;
            gather_q <= '0;
        end
        else if (take_byte)
        begin
            // clear so a partial last word comes out zero padded
            gather_q <= (word_done || last_byte) ? '0 : gather_word;
        end
    end

endmodule

// ==== logic/rx_word_fifo.sv ====
// word FIFO between packer and stream master, credits on both sides
`timescale 1ns/1ps

module rx_word_fifo
    import rx_format_pkg::*;
#(
    parameter int fifo_depth = 32,
    parameter int out_slots  = 2
)
(
    input  logic        m00_axis_aclk,
    input  logic        arst_n,
    rx_word_if.receiver push,
    rx_word_if.sender   pop
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);
    localparam int oc_w  = $clog2(out_slots + 1);

    word_t            mem_data [fifo_depth];
    logic             mem_last [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [oc_w-1:0]  out_credits;
    logic             fwd;

    function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(fifo_depth - 1))
            return '0;
        return ptr + ptr_w'(1);
    endfunction

    // forward the head word while the stream master has room for it
    assign fwd        = (count != '0) && (out_credits != '0);
    assign pop.valid  = fwd;
    assign pop.data   = mem_data[rd_ptr];
    assign pop.last   = mem_last[rd_ptr];
    assign push.level = count;

    always_ff @(posedge m00_axis_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            out_credits <= oc_w'(out_slots);
            push.credit <= 1'b0;
        end
        else
        begin
            count       <= count + cnt_w'(push.valid) - cnt_w'(fwd);
            out_credits <= out_credits + oc_w'(pop.credit) - oc_w'(fwd);
            // slot freed, hand it back to the packer
            push.credit <= fwd;
            if (push.valid)
                wr_ptr <= bump(wr_ptr);
            if (fwd)
                rd_ptr <= bump(rd_ptr);
        end
    end

    always_ff @(posedge m00_axis_aclk)
    begin
        if (push.valid)
        begin
            mem_data[wr_ptr] <= push.data;
            mem_last[wr_ptr] <= push.last;
        end
    end

endmodule

// ==== logic/rx_dma_streamer.sv ====
// stream master with a small output queue, tlast and the packet interrupt
`timescale 1ns/1ps

module rx_dma_streamer
    import rx_format_pkg::*;
    import rx_fsm_pkg::*;
#(
    parameter int out_slots = 2
)
(
    input  logic        m00_axis_aclk,
    input  logic        arst_n,
    rx_word_if.receiver fill,
    output logic        m00_axis_tvalid,
    output word_t       m00_axis_tdata,
    output logic        m00_axis_tlast,
    input  logic        m00_axis_tready,
    output logic        rx_pkt_intr
);

    localparam int ptr_w = (out_slots > 1) ? $clog2(out_slots) : 1;
    localparam int cnt_w = $clog2(out_slots + 1);

    streamer_state_e  state;
    word_t            q_data [out_slots];
    logic             q_last [out_slots];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             xfer;

    function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(out_slots - 1))
            return '0;
        return ptr + ptr_w'(1);
    endfunction

    // head of queue stays put until the transfer
    assign m00_axis_tvalid = count != '0;
    assign m00_axis_tdata  = q_data[rd_ptr];
    assign m00_axis_tlast  = q_last[rd_ptr];
    assign xfer            = m00_axis_tvalid && m00_axis_tready;
    assign fill.level      = count;

    always_ff @(posedge m00_axis_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= st_idle;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            fill.credit <= 1'b0;
            rx_pkt_intr <= 1'b0;
        end
        else
        begin
            count       <= count + cnt_w'(fill.valid) - cnt_w'(xfer);
            fill.credit <= xfer;
            // packet closes with the status word
            rx_pkt_intr <= xfer && m00_axis_tlast && state == st_streaming;
            if (fill.valid)
                wr_ptr <= bump(wr_ptr);
            if (xfer)
                rd_ptr <= bump(rd_ptr);

            case (state)
                st_idle:
                    if (xfer && !m00_axis_tlast)
                        state <= st_streaming;
                st_streaming:
                    if (xfer && m00_axis_tlast)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge m00_axis_aclk)
    begin
        if (fill.valid)
        begin
            q_data[wr_ptr] <= fill.data;
            q_last[wr_ptr] <= fill.last;
        end
    end

endmodule

// ==== logic/rx_intf.sv ====
// receive packet path top: packer, word FIFO and stream master
`timescale 1ns/1ps

module rx_intf
    import rx_format_pkg::*;
#(
    parameter int fifo_depth = 32,
    parameter int out_slots  = 2
)
(
    input  logic        m00_axis_aclk,
    input  logic        arst_n,

    // from the OFDM receiver
    input  logic        pkt_header_valid,
    input  logic        pkt_header_valid_strobe,
    input  logic [7:0]  pkt_rate,
    input  len_t        pkt_len,
    input  logic [7:0]  byte_in,
    input  logic        byte_in_strobe,
    input  logic        fcs_in_strobe,
    input  logic        fcs_ok,
    input  logic [63:0] tsf_runtime_val,

    // stream master towards the DMA
    output logic        m00_axis_tvalid,
    output word_t       m00_axis_tdata,
    output logic        m00_axis_tlast,
    input  logic        m00_axis_tready,

    output logic        rx_pkt_intr,
    output logic [15:0] dropped_pkt_count
);

    rx_word_if #(.slots(fifo_depth)) pack_if ();
    rx_word_if #(.slots(out_slots))  out_if ();

    rx_word_packer #(
        .fifo_depth (fifo_depth)
    ) packer_i (
        .m00_axis_aclk           (m00_axis_aclk),
        .arst_n                  (arst_n),
        .pkt_header_valid        (pkt_header_valid),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .pkt_rate                (pkt_rate),
        .pkt_len                 (pkt_len),
        .byte_in                 (byte_in),
        .byte_in_strobe          (byte_in_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .tsf_runtime_val         (tsf_runtime_val),
        .dropped_pkt_count       (dropped_pkt_count),
        .push                    (pack_if.sender)
    );

    rx_word_fifo #(
        .fifo_depth (fifo_depth),
        .out_slots  (out_slots)
    ) fifo_i (
        .m00_axis_aclk (m00_axis_aclk),
        .arst_n        (arst_n),
        .push          (pack_if.receiver),
        .pop           (out_if.sender)
    );

    rx_dma_streamer #(
        .out_slots (out_slots)
    ) streamer_i (
        .m00_axis_aclk   (m00_axis_aclk),
        .arst_n          (arst_n),
        .fill            (out_if.receiver),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tlast  (m00_axis_tlast),
        .m00_axis_tready (m00_axis_tready),
        .rx_pkt_intr     (rx_pkt_intr)
    );

endmodule

// ==== verification/rx_intf_tb.sv ====
// testbench for the receive packet path with packet table, reference model, stream monitor and watchdog
`timescale 1ns/1ps

module rx_intf_tb
    import rx_format_pkg::*;
();

    localparam int fifo_depth = 32;
    localparam int out_slots  = 2;
    localparam int n_rows     = 16;
    localparam int settle     = 6;

    // tready behaviour of a table row
    localparam logic [1:0] ready_high   = 2'd0;
    localparam logic [1:0] ready_random = 2'd1;
    localparam logic [1:0] ready_hold   = 2'd2;

    typedef struct packed
    {
        len_t       len;
        logic [7:0] rate;
        logic       fcs;
        logic       hdr_valid;
        logic [1:0] ready_mode;
        logic       drop;
    } pkt_row_t;

    logic        m00_axis_aclk = 1'b0;
    logic        arst_n;
    logic        pkt_header_valid;
    logic        pkt_header_valid_strobe;
    logic [7:0]  pkt_rate;
    len_t        pkt_len;
    logic [7:0]  byte_in;
    logic        byte_in_strobe;
    logic        fcs_in_strobe;
    logic        fcs_ok;
    logic [63:0] tsf_runtime_val;
    logic        m00_axis_tvalid;
    word_t       m00_axis_tdata;
    logic        m00_axis_tlast;
    logic        m00_axis_tready;
    logic        rx_pkt_intr;
    logic [15:0] dropped_pkt_count;

    pkt_row_t    rows [n_rows];
    logic        rows_loaded = 1'b0;
    logic [1:0]  ready_mode;
    logic [1:0]  prev_mode;
    logic [31:0] rng_data;
    logic [31:0] rng_ready;
    // expected stream words with tlast in the top bit
    logic [64:0] exp_q [$];
    logic [64:0] exp_word;
    seq_t        model_seq;
    int          model_drops;
    logic        intr_due;
    logic        stalled;
    word_t       stall_data;
    logic        stall_last;

    rx_intf #(
        .fifo_depth (fifo_depth),
        .out_slots  (out_slots)
    ) rx_intf_i (
        .m00_axis_aclk           (m00_axis_aclk),
        .arst_n                  (arst_n),
        .pkt_header_valid        (pkt_header_valid),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .pkt_rate                (pkt_rate),
        .pkt_len                 (pkt_len),
        .byte_in                 (byte_in),
        .byte_in_strobe          (byte_in_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .tsf_runtime_val         (tsf_runtime_val),
        .m00_axis_tvalid         (m00_axis_tvalid),
        .m00_axis_tdata          (m00_axis_tdata),
        .m00_axis_tlast          (m00_axis_tlast),
        .m00_axis_tready         (m00_axis_tready),
        .rx_pkt_intr             (rx_pkt_intr),
        .dropped_pkt_count       (dropped_pkt_count)
    );

    always #2 m00_axis_aclk = ~m00_axis_aclk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // length in 15:0, rate in 23:16, low timestamp half on top
    function automatic word_t header_word(input len_t len, input logic [7:0] rate,
                                          input logic [63:0] tsf);
        return {tsf[31:0], 8'h00, rate, len};
    endfunction

    function automatic word_t status_word(input logic fcs, input seq_t seq);
        return {32'h0, seq, 15'h0, fcs};
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        if (exp !== got)
        begin
            $display("[FAIL] %s exp %h got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic set_row(input int i, input len_t len, input logic [7:0] rate,
                           input logic fcs, input logic hv, input logic [1:0] mode,
                           input logic drop);
        rows[i].len        = len;
        rows[i].rate       = rate;
        rows[i].fcs        = fcs;
        rows[i].hdr_valid  = hv;
        rows[i].ready_mode = mode;
        rows[i].drop       = drop;
    endtask

    task automatic load_rows();
        set_row(0,  16,  8'h0b, 1'b1, 1'b1, ready_high,   1'b0);
        set_row(1,  13,  8'h0f, 1'b0, 1'b1, ready_high,   1'b0);
        set_row(2,  8,   8'h0a, 1'b1, 1'b0, ready_high,   1'b0);
        set_row(3,  1,   8'h0e, 1'b1, 1'b1, ready_high,   1'b0);
        set_row(4,  37,  8'h09, 1'b1, 1'b1, ready_random, 1'b0);
        set_row(5,  24,  8'h0d, 1'b0, 1'b1, ready_random, 1'b0);
        set_row(6,  100, 8'h08, 1'b1, 1'b1, ready_random, 1'b0);
        // burst with the stream stalled and 34 words of room in total
        set_row(7,  64,  8'h0c, 1'b1, 1'b1, ready_hold,   1'b0);
        set_row(8,  64,  8'h0b, 1'b0, 1'b1, ready_hold,   1'b0);
        set_row(9,  64,  8'h0f, 1'b1, 1'b1, ready_hold,   1'b0);
        set_row(10, 40,  8'h0a, 1'b1, 1'b1, ready_hold,   1'b1);
        set_row(11, 8,   8'h0e, 1'b1, 1'b1, ready_hold,   1'b0);
        set_row(12, 1,   8'h09, 1'b0, 1'b1, ready_hold,   1'b1);
        set_row(13, 5,   8'h0d, 1'b1, 1'b0, ready_hold,   1'b0);
        set_row(14, 20,  8'h0c, 1'b1, 1'b1, ready_high,   1'b0);
        set_row(15, 9,   8'h08, 1'b1, 1'b1, ready_random, 1'b0);
    endtask

    task automatic set_ready_mode(input logic [1:0] mode);
        @(posedge m00_axis_aclk);
        ready_mode = mode;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(negedge m00_axis_aclk);
    endtask

    // the stream stays stalled only between two held rows
    task automatic prepare_ready(input logic [1:0] prev, input logic [1:0] cur);
        if (!(prev == ready_hold && cur == ready_hold))
        begin
            set_ready_mode((cur == ready_hold) ? ready_high : cur);
            wait_drain();
            set_ready_mode(cur);
        end
        repeat (settle) @(negedge m00_axis_aclk);
    endtask

    task automatic run_row(input pkt_row_t row);
        logic [7:0]  pkt_bytes [$];
        logic [63:0] tsf;
        word_t       word;
        logic        admit;
        int          n_words;
        int          pending;
        int          avail;
        int          drops_before;
        int          b;
        int          w;
        int          k;
        n_words      = (row.len + bytes_per_word - 1) / bytes_per_word;
        drops_before = model_drops;
        for (b = 0; b < row.len; b++)
        begin
            rng_data = xorshift(rng_data);
            pkt_bytes.push_back(rng_data[7:0]);
        end
        rng_data    = xorshift(rng_data);
        tsf[63:32]  = rng_data;
        rng_data    = xorshift(rng_data);
        tsf[31:0]   = rng_data;

        // settled credits are the FIFO slots not taken by words beyond the output queue
        pending = exp_q.size();
        avail   = (pending > out_slots) ? fifo_depth - (pending - out_slots) : fifo_depth;
        admit   = row.hdr_valid && (2 + n_words <= avail);
        if (row.hdr_valid && !admit)
            model_drops++;
        if (admit)
        begin
            exp_q.push_back({1'b0, header_word(row.len, row.rate, tsf)});
            for (w = 0; w < n_words; w++)
            begin
                word = '0;
                for (k = 0; k < bytes_per_word; k++)
                    if (w * bytes_per_word + k < row.len)
                        word[8*k +: 8] = pkt_bytes[w * bytes_per_word + k];
                exp_q.push_back({1'b0, word});
            end
            exp_q.push_back({1'b1, status_word(row.fcs, model_seq)});
            model_seq++;
        end

        @(negedge m00_axis_aclk);
        pkt_header_valid_strobe = 1'b1;
        pkt_header_valid        = row.hdr_valid;
        pkt_len                 = row.len;
        pkt_rate                = row.rate;
        tsf_runtime_val         = tsf;
        @(negedge m00_axis_aclk);
        pkt_header_valid_strobe = 1'b0;
        for (b = 0; b < row.len; b++)
        begin
            @(negedge m00_axis_aclk);
            byte_in        = pkt_bytes[b];
            byte_in_strobe = 1'b1;
        end
        @(negedge m00_axis_aclk);
        byte_in_strobe = 1'b0;
        // receiver leaves an idle cycle before the FCS result
        @(negedge m00_axis_aclk);
        fcs_in_strobe = 1'b1;
        fcs_ok        = row.fcs;
        @(negedge m00_axis_aclk);
        fcs_in_strobe = 1'b0;
        repeat (settle) @(negedge m00_axis_aclk);
        check_value("dropped_pkt_count", drops_before + row.drop, dropped_pkt_count);
        check_value("dropped_pkt_count", model_drops, dropped_pkt_count);
    endtask

    always @(negedge m00_axis_aclk)
    begin
        case (ready_mode)
            ready_random:
            begin
                rng_ready       = xorshift(rng_ready);
                m00_axis_tready = rng_ready[4];
            end
            ready_hold:
                m00_axis_tready = 1'b0;
            default:
                m00_axis_tready = 1'b1;
        endcase
    end

    // stream monitor sampling the registered outputs at the rising edge
    always @(posedge m00_axis_aclk)
    begin
        if (arst_n)
        begin
            check_value("rx_pkt_intr", intr_due, rx_pkt_intr);
            if (stalled)
            begin
                check_value("m00_axis_tvalid", 1'b1, m00_axis_tvalid);
                check_value("m00_axis_tdata", stall_data, m00_axis_tdata);
                check_value("m00_axis_tlast", stall_last, m00_axis_tlast);
            end
            if (m00_axis_tvalid && m00_axis_tready)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("stream delivered a word while no word was expected");
                    abort_run();
                end
                exp_word = exp_q.pop_front();
                check_value("m00_axis_tdata", exp_word[63:0], m00_axis_tdata);
                check_value("m00_axis_tlast", exp_word[64], m00_axis_tlast);
            end
            intr_due   = m00_axis_tvalid && m00_axis_tready && m00_axis_tlast;
            stalled    = m00_axis_tvalid && !m00_axis_tready;
            stall_data = m00_axis_tdata;
            stall_last = m00_axis_tlast;
        end
    end

    initial
    begin
        int total;
        int limit;
        int i;
        wait (rows_loaded);
        total = 0;
        for (i = 0; i < n_rows; i++)
            total += rows[i].len;
        limit = total * 20 + 2000;
        repeat (limit) @(posedge m00_axis_aclk);
        $display("watchdog timeout, the run did not finish within %0d cycles", limit);
        abort_run();
    end

    initial
    begin
        int i;
        arst_n                  = 1'b0;
        pkt_header_valid        = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        pkt_rate                = '0;
        pkt_len                 = '0;
        byte_in                 = '0;
        byte_in_strobe          = 1'b0;
        fcs_in_strobe           = 1'b0;
        fcs_ok                  = 1'b0;
        tsf_runtime_val         = '0;
        m00_axis_tready         = 1'b1;
        ready_mode              = ready_high;
        prev_mode               = ready_high;
        rng_data                = 32'd16;
        rng_ready               = 32'd16;
        model_seq               = '0;
        model_drops             = 0;
        intr_due                = 1'b0;
        stalled                 = 1'b0;
        load_rows();
        rows_loaded = 1'b1;

        repeat (8) @(posedge m00_axis_aclk);
        @(negedge m00_axis_aclk);
        arst_n = 1'b1;
        check_value("m00_axis_tvalid", 1'b0, m00_axis_tvalid);
        check_value("rx_pkt_intr", 1'b0, rx_pkt_intr);
        check_value("dropped_pkt_count", 16'd0, dropped_pkt_count);

        for (i = 0; i < n_rows; i++)
        begin
            prepare_ready(prev_mode, rows[i].ready_mode);
            run_row(rows[i]);
            prev_mode = rows[i].ready_mode;
        end

        set_ready_mode(ready_high);
        wait_drain();
        repeat (settle) @(negedge m00_axis_aclk);
        check_value("dropped_pkt_count", model_drops, dropped_pkt_count);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== rx_intf.f ====
logic/rx_format_pkg.sv
logic/rx_fsm_pkg.sv
logic/rx_word_if.sv
logic/rx_word_packer.sv
logic/rx_word_fifo.sv
logic/rx_dma_streamer.sv
logic/rx_intf.sv
verification/rx_intf_tb.sv

// ==== Bender.yml ====
package:
  name: rx_intf

sources:
  - logic/rx_format_pkg.sv
  - logic/rx_fsm_pkg.sv
  - logic/rx_word_if.sv
  - logic/rx_word_packer.sv
  - logic/rx_word_fifo.sv
  - logic/rx_dma_streamer.sv
  - logic/rx_intf.sv
  - target: test
    files:
      - verification/rx_intf_tb.sv
